/* parameters.svh */
`ifndef PARAMETERS_SVH
`define PARAMETERS_SVH

// Width of one write-mask lane
`define BYTE_LEN_IN_BITS 8

`endif

/* cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

    // Basic widths
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;

    // Byte offset within one line
    localparam int OFFSET_WIDTH   = $clog2(BYTES_PER_WORD * WORDS_PER_LINE);

    // Byte address as seen on the request port
    typedef logic [ADDR_WIDTH - 1 : 0]                      addr_t;

    typedef logic [WORD_WIDTH - 1 : 0]                      word_t;
    typedef logic [LINE_WIDTH - 1 : 0]                      line_t;

    // One enable per byte lane
    typedef logic [BYTES_PER_WORD - 1 : 0]                  word_mask_t;
    typedef logic [BYTES_PER_WORD * WORDS_PER_LINE - 1 : 0] line_mask_t;

endpackage

`default_nettype wire

/* cache_msg_pkg.sv */
`default_nettype none

package cache_msg_pkg;

    // Request operation
    typedef enum logic [1 : 0]
    {
        CACHE_OP_READ  = 2'd0,
        CACHE_OP_WRITE = 2'd1,
        CACHE_OP_FILL  = 2'd2
    } cache_op_e;

    // Incoming request; fill_line only matters for a fill
    typedef struct packed
    {
        cache_op_e                   op;
        cache_cfg_pkg::addr_t        addr;
        cache_cfg_pkg::word_t        wdata;
        cache_cfg_pkg::word_mask_t   wmask;
        cache_cfg_pkg::line_t        fill_line;
    } cache_req_t;

    // Outgoing response for reads and writes
    typedef struct packed
    {
        cache_op_e                   op;
        logic                        hit;
        cache_cfg_pkg::word_t        rdata;
    } cache_resp_t;

    // Carried alongside the RAM access into the response stage
    typedef struct packed
    {
        cache_op_e                   op;
        logic                        hit;
        logic [$clog2(cache_cfg_pkg::WORDS_PER_LINE) - 1 : 0] word_sel;
    } lookup_to_resp_t;

endpackage

`default_nettype wire

/* single_port_blockram.sv */
`include "parameters.svh"

`default_nettype none

module single_port_blockram
#(
    parameter SINGLE_ENTRY_WIDTH_IN_BITS = 64,
    parameter NUM_SET                    = 64,
    parameter SET_PTR_WIDTH_IN_BITS      = $clog2(NUM_SET),
    parameter WRITE_MASK_LEN             = SINGLE_ENTRY_WIDTH_IN_BITS / `BYTE_LEN_IN_BITS,
    parameter WITH_VALID_REG_ARRAY       = "Yes"
)
(
    input  wire logic                                      clk_in,
    input  wire logic                                      reset_in,

    input  wire logic                                      access_en_in,
    input  wire logic [WRITE_MASK_LEN - 1 : 0]             write_en_in,
    input  wire logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]      access_set_addr_in,

    input  wire logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] write_entry_in,
    output logic      [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] read_entry_out,
    output logic                                           read_valid_out
);

    logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] blockram [NUM_SET];

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : g_valid_array
            logic [NUM_SET - 1 : 0] valid_array;   // One bit per set, set on any write

            always_ff @(posedge clk_in)
            begin
                if (reset_in)
                begin
                    valid_array    <= '0;
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    if (access_en_in && |write_en_in)
                    begin
                        valid_array[access_set_addr_in] <= 1'b1;
                    end

                    // Old valid state, same as the data read
                    read_valid_out <= access_en_in && valid_array[access_set_addr_in];
                end
            end
        end
        else
        begin : g_no_valid_array
            // Without the array, a line is valid whenever it was read
            always_ff @(posedge clk_in)
            begin
                if (reset_in)
                begin
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    read_valid_out <= access_en_in;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk_in)
    begin
        if (access_en_in)
        begin
            for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
            begin
                if (write_en_in[lane])
                begin
                    blockram[access_set_addr_in][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                        <= write_entry_in[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
                end
            end

            read_entry_out <= blockram[access_set_addr_in];   // Read before write
        end
    end

endmodule

`default_nettype wire

/* cache_lookup_stage.sv */
`default_nettype none

module cache_lookup_stage
#(
    parameter int NUM_SET = 64
)
(
    input  wire logic                           clk_in,
    input  wire logic                           reset_in,

    input  wire logic                           req_valid,
    input  wire cache_msg_pkg::cache_req_t      req,

    output logic                                ram_access_en,
    output cache_cfg_pkg::line_mask_t           ram_write_en,
    output logic [$clog2(NUM_SET) - 1 : 0]      ram_set,
    output cache_cfg_pkg::line_t                ram_wdata,

    output logic                                meta_valid,
    output cache_msg_pkg::lookup_to_resp_t      meta
);

    localparam int SET_WIDTH      = $clog2(NUM_SET);
    localparam int TAG_WIDTH      = cache_cfg_pkg::ADDR_WIDTH - cache_cfg_pkg::OFFSET_WIDTH
                                    - SET_WIDTH;
    localparam int BYTE_SEL_WIDTH = $clog2(cache_cfg_pkg::BYTES_PER_WORD);
    localparam int WORD_SEL_WIDTH = $clog2(cache_cfg_pkg::WORDS_PER_LINE);

    typedef logic [TAG_WIDTH - 1 : 0] tag_t;

    logic                        req_valid_q;
    cache_msg_pkg::cache_req_t   req_q;

    tag_t                        tag_array [NUM_SET];
    logic [NUM_SET - 1 : 0]      valid_bits;

    tag_t                        req_tag;
    logic [SET_WIDTH - 1 : 0]    req_set;
    logic [WORD_SEL_WIDTH - 1 : 0] req_word_sel;
    logic                        hit;
    logic                        is_fill;
    logic                        is_write;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            req_valid_q <= 1'b0;
        end
        else
        begin
            req_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk_in)
    begin
        req_q <= req;
    end

    // Address fields of the registered request
    assign req_tag      = req_q.addr[cache_cfg_pkg::ADDR_WIDTH - 1 -: TAG_WIDTH];
    assign req_set      = req_q.addr[cache_cfg_pkg::OFFSET_WIDTH +: SET_WIDTH];
    assign req_word_sel = req_q.addr[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];

    assign is_fill  = req_q.op == cache_msg_pkg::CACHE_OP_FILL;
    assign is_write = req_q.op == cache_msg_pkg::CACHE_OP_WRITE;
    assign hit      = valid_bits[req_set] && (tag_array[req_set] == req_tag);

    // A fill installs the tag together with the RAM write
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            valid_bits <= '0;
        end
        else if (req_valid_q && is_fill)
        begin
            valid_bits[req_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (req_valid_q && is_fill)
        begin
            tag_array[req_set] <= req_tag;
        end
    end

    assign ram_access_en = req_valid_q;
    assign ram_set       = req_set;

    always_comb
    begin
        ram_write_en = '0;
        ram_wdata    = cache_cfg_pkg::line_t'(req_q.wdata)
                       << (req_word_sel * cache_cfg_pkg::WORD_WIDTH);
        if (req_valid_q && is_fill)
        begin
            ram_write_en = '1;
            ram_wdata    = req_q.fill_line;
        end
        else if (req_valid_q && is_write && hit)
        begin
            // Word mask moved into its lane; write miss stays all zero
            ram_write_en = cache_cfg_pkg::line_mask_t'(req_q.wmask)
                           << (req_word_sel * cache_cfg_pkg::BYTES_PER_WORD);
        end
    end

    assign meta_valid    = req_valid_q && !is_fill;   // Fills get no response
    assign meta.op       = req_q.op;
    assign meta.hit      = hit;
    assign meta.word_sel = req_word_sel;

    a_write_needs_access : assert property (@(posedge clk_in) disable iff (reset_in)
        |ram_write_en |-> ram_access_en);

    a_no_meta_for_fill : assert property (@(posedge clk_in) disable iff (reset_in)
        meta_valid |-> meta.op != cache_msg_pkg::CACHE_OP_FILL);

endmodule

`default_nettype wire

/* cache_response_stage.sv */
`default_nettype none

module cache_response_stage
(
    input  wire logic                           clk_in,
    input  wire logic                           reset_in,

    input  wire logic                           meta_valid,
    input  wire cache_msg_pkg::lookup_to_resp_t meta,
    input  wire cache_cfg_pkg::line_t           ram_line,

    output logic                                resp_valid,
    output cache_msg_pkg::cache_resp_t          resp
);

    logic                            meta_valid_q;
    cache_msg_pkg::lookup_to_resp_t  meta_q;   // Lines up with ram_line
    cache_cfg_pkg::word_t            sel_word;
    logic                            read_hit;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            meta_valid_q <= 1'b0;
            resp_valid   <= 1'b0;
        end
        else
        begin
            meta_valid_q <= meta_valid;
            resp_valid   <= meta_valid_q;
        end
    end

    assign sel_word = ram_line[meta_q.word_sel * cache_cfg_pkg::WORD_WIDTH +:
                               cache_cfg_pkg::WORD_WIDTH];
    assign read_hit = meta_q.hit && (meta_q.op == cache_msg_pkg::CACHE_OP_READ);

    always_ff @(posedge clk_in)
    begin
        meta_q     <= meta;
        resp.op    <= meta_q.op;
        resp.hit   <= meta_q.hit;
        resp.rdata <= read_hit ? sel_word : '0;   // Zero on miss and on writes
    end

    // Every response traces back to a lookup two cycles earlier
    a_resp_from_meta : assert property (@(posedge clk_in) disable iff (reset_in)
        resp_valid |-> $past(meta_valid, 2));

endmodule

`default_nettype wire

/* cache_top.sv */
`default_nettype none

module cache_top
#(
    parameter int NUM_SET = 64
)
(
    input  wire logic                      clk_in,
    input  wire logic                      reset_in,

    input  wire logic                      req_valid,
    input  wire cache_msg_pkg::cache_req_t req,

    output logic                           resp_valid,
    output cache_msg_pkg::cache_resp_t     resp
);

    localparam int SET_WIDTH = $clog2(NUM_SET);

    logic                            ram_access_en;
    cache_cfg_pkg::line_mask_t       ram_write_en;
    logic [SET_WIDTH - 1 : 0]        ram_set;
    cache_cfg_pkg::line_t            ram_wdata;
    cache_cfg_pkg::line_t            ram_line;

    logic                            meta_valid;
    cache_msg_pkg::lookup_to_resp_t  meta;

    cache_lookup_stage
    #(
        .NUM_SET (NUM_SET)
    )
    lookup0
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .req_valid     (req_valid),
        .req           (req),
        .ram_access_en (ram_access_en),
        .ram_write_en  (ram_write_en),
        .ram_set       (ram_set),
        .ram_wdata     (ram_wdata),
        .meta_valid    (meta_valid),
        .meta          (meta)
    );

    // Hit tracking lives in the lookup stage, so no RAM valid array
    single_port_blockram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (cache_cfg_pkg::LINE_WIDTH),
        .NUM_SET                    (NUM_SET),
        .SET_PTR_WIDTH_IN_BITS      (SET_WIDTH),
        .WRITE_MASK_LEN             ($bits(cache_cfg_pkg::line_mask_t)),
        .WITH_VALID_REG_ARRAY       ("No")
    )
    data_ram0
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en_in       (ram_access_en),
        .write_en_in        (ram_write_en),
        .access_set_addr_in (ram_set),
        .write_entry_in     (ram_wdata),
        .read_entry_out     (ram_line),
        .read_valid_out     ()
    );

    cache_response_stage resp0
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .meta_valid (meta_valid),
        .meta       (meta),
        .ram_line   (ram_line),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

/* tb_cache.sv */
`default_nettype none

module tb_cache;

    localparam int NUM_SET       = 64;
    localparam int SET_WIDTH     = $clog2(NUM_SET);
    localparam int TAG_WIDTH     = cache_cfg_pkg::ADDR_WIDTH - cache_cfg_pkg::OFFSET_WIDTH
                                   - SET_WIDTH;
    localparam int RESET_CYCLES  = 4;
    localparam int NUM_TESTS     = 6;
    localparam int DIRECTED_REQS = 21;
    localparam int NUM_RANDOM    = 300;
    localparam int DRAIN_LIMIT   = 8;
    // Every request, the drain after each test, reset and some slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_REQS + NUM_RANDOM
                                     + NUM_TESTS * (DRAIN_LIMIT + 1) + 20;

    logic                         clk_in;
    logic                         reset_in;
    logic                         req_valid;
    cache_msg_pkg::cache_req_t    req;
    logic                         resp_valid;
    cache_msg_pkg::cache_resp_t   resp;

    // Reference copy of the cache contents
    logic [TAG_WIDTH - 1 : 0]     ref_tag [NUM_SET];
    logic [NUM_SET - 1 : 0]       ref_valid;
    cache_cfg_pkg::line_t         ref_line [NUM_SET];

    cache_msg_pkg::cache_resp_t   exp_q [$];
    int                           errors;
    int                           checks;
    int                           test_num;
    int                           errors_at_start;
    int                           seed;
    logic [31 : 0]                rnd;
    cache_msg_pkg::cache_op_e     rnd_op;
    cache_cfg_pkg::line_t         fill_a;
    cache_cfg_pkg::line_t         fill_b;

    cache_top #(.NUM_SET(NUM_SET)) dut0
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    function automatic cache_cfg_pkg::addr_t make_addr(int tag, int set, int word);
        return {TAG_WIDTH'(tag), SET_WIDTH'(set), 2'(word), 2'b00};
    endfunction

    // Expected response from the reference state before this request
    function automatic cache_msg_pkg::cache_resp_t predict(cache_msg_pkg::cache_req_t r);
        cache_msg_pkg::cache_resp_t p;
        int s;
        int w;
        s       = r.addr[cache_cfg_pkg::OFFSET_WIDTH +: SET_WIDTH];
        w       = r.addr[2 +: 2];
        p.op    = r.op;
        p.hit   = ref_valid[s] && ref_tag[s] == r.addr[cache_cfg_pkg::ADDR_WIDTH - 1 -: TAG_WIDTH];
        p.rdata = '0;
        if (r.op == cache_msg_pkg::CACHE_OP_READ && p.hit)
        begin
            p.rdata = ref_line[s][w * 32 +: 32];
        end
        return p;
    endfunction

    task automatic update_model(cache_msg_pkg::cache_req_t r, logic hit);
        int s;
        int w;
        s = r.addr[cache_cfg_pkg::OFFSET_WIDTH +: SET_WIDTH];
        w = r.addr[2 +: 2];
        if (r.op == cache_msg_pkg::CACHE_OP_FILL)
        begin
            ref_tag[s]   = r.addr[cache_cfg_pkg::ADDR_WIDTH - 1 -: TAG_WIDTH];
            ref_valid[s] = 1'b1;
            ref_line[s]  = r.fill_line;
        end
        else if (r.op == cache_msg_pkg::CACHE_OP_WRITE && hit)   // No allocate on a miss
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (r.wmask[b])
                begin
                    ref_line[s][w * 32 + b * 8 +: 8] = r.wdata[b * 8 +: 8];
                end
            end
        end
    endtask

    task automatic issue(cache_msg_pkg::cache_op_e op, cache_cfg_pkg::addr_t addr,
                         cache_cfg_pkg::word_t wdata, cache_cfg_pkg::word_mask_t wmask,
                         cache_cfg_pkg::line_t fill_line);
        cache_msg_pkg::cache_req_t  r;
        cache_msg_pkg::cache_resp_t p;
        r.op        = op;
        r.addr      = addr;
        r.wdata     = wdata;
        r.wmask     = wmask;
        r.fill_line = fill_line;
        p           = predict(r);
        @(posedge clk_in);
        req_valid <= 1'b1;
        req       <= r;
        if (op != cache_msg_pkg::CACHE_OP_FILL)
        begin
            exp_q.push_back(p);
        end
        update_model(r, p.hit);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk_in);
        req_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(posedge clk_in);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d responses still owed when the test ended", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
        end
    endtask

    task automatic end_test(string name);
        drain();
        test_num++;
        $display("Test %0d %s: %s (%0d mismatches)", test_num, name,
                 (errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic check_op(string name, cache_msg_pkg::cache_op_e exp,
                            cache_msg_pkg::cache_op_e got);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_hit(string name, bit exp, logic got);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_word(string name, cache_cfg_pkg::word_t exp, cache_cfg_pkg::word_t got);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk_in)
    begin : compare_resp
        cache_msg_pkg::cache_resp_t exp_resp;
        if (!reset_in && resp_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("A response arrived while no request was outstanding");
                errors++;
            end
            else
            begin
                exp_resp = exp_q.pop_front();
                check_op("resp.op", exp_resp.op, resp.op);
                check_hit("resp.hit", exp_resp.hit, resp.hit);
                check_word("resp.rdata", exp_resp.rdata, resp.rdata);
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    initial
    begin
        reset_in        = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        ref_valid       = '0;
        errors          = 0;
        checks          = 0;
        test_num        = 0;
        errors_at_start = 0;
        seed            = 21074;
        fill_a          = {32'h4444_0003, 32'h3333_0002, 32'h2222_0001, 32'h1111_0000};
        fill_b          = {32'hDDDD_0303, 32'hCCCC_0202, 32'hBBBB_0101, 32'hAAAA_0000};
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset_in <= 1'b0;

        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(1, 0, 0), '0, '0, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(1, 5, 1), '0, '0, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(1, 17, 2), '0, '0, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(1, 63, 3), '0, '0, '0);
        end_test("reads after reset miss");

        issue(cache_msg_pkg::CACHE_OP_FILL, make_addr(3, 9, 0), '0, '0, fill_a);
        for (int w = 0; w < 4; w++)
        begin
            issue(cache_msg_pkg::CACHE_OP_READ, make_addr(3, 9, w), '0, '0, '0);
        end
        end_test("fill then read all words");

        issue(cache_msg_pkg::CACHE_OP_WRITE, make_addr(3, 9, 2), 32'hA5A5_5A5A, 4'b0101, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(3, 9, 2), '0, '0, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(3, 9, 1), '0, '0, '0);
        end_test("partial write hit merges bytes");

        // Same set, other tag
        issue(cache_msg_pkg::CACHE_OP_WRITE, make_addr(7, 9, 1), 32'hFFFF_FFFF, 4'b1111, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(7, 9, 1), '0, '0, '0);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(3, 9, 1), '0, '0, '0);
        end_test("write miss does not allocate");

        issue(cache_msg_pkg::CACHE_OP_FILL, make_addr(5, 9, 0), '0, '0, fill_b);
        issue(cache_msg_pkg::CACHE_OP_READ, make_addr(3, 9, 0), '0, '0, '0);
        for (int w = 0; w < 4; w++)
        begin
            issue(cache_msg_pkg::CACHE_OP_READ, make_addr(5, 9, w), '0, '0, '0);
        end
        end_test("fill evicts old tag");

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rnd = $unsigned($random(seed));
            if (rnd[2 : 0] < 3)
                rnd_op = cache_msg_pkg::CACHE_OP_READ;
            else if (rnd[2 : 0] < 6)
                rnd_op = cache_msg_pkg::CACHE_OP_WRITE;
            else
                rnd_op = cache_msg_pkg::CACHE_OP_FILL;
            issue(rnd_op, make_addr(rnd[4:3] % 3, (rnd[6:5] == 0) ? 40 : rnd[6:5], rnd[8:7]),
                  $random(seed), rnd[12:9],
                  {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        end_test("random back-to-back traffic");

        $display("Tests %0d, checks %0d, mismatches %0d", test_num, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
cache_cfg_pkg.sv
cache_msg_pkg.sv
single_port_blockram.sv
cache_lookup_stage.sv
cache_response_stage.sv
cache_top.sv
tb_cache.sv
